// File: Makefile
# Verilator flow for the Wishbone SRAM block
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
FILELIST  ?= verilog.f
RTL_TOP   ?= wb_sram_top
TB_TOP    ?= tb_wb_sram
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: common/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// array geometry
`define MEM_DW    32   // data word width
`define MEM_DEPTH 256  // words in the array
`define MEM_AW    8    // word address width, log2 of depth

// bus side
`define MEM_SW    4    // byte selects per word

`endif

// File: common/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

   // one data word
   // same shape is reused as the bit write mask
   typedef logic [`MEM_DW-1:0] mem_word_t;

   // word address into the array
   typedef logic [`MEM_AW-1:0] mem_addr_t;

   // wishbone byte selects, one per byte lane
   typedef logic [`MEM_SW-1:0] mem_sel_t;

endpackage

// File: common/mem_req_if.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

// single-cycle request path from the bus decoder to the array
// the ack side only watches
interface mem_req_if;

   logic                valid;  // request this cycle
   logic                we;     // write when high
   mem_pkg::mem_addr_t  addr;   // word address
   mem_pkg::mem_word_t  wem;    // per bit write enable
   mem_pkg::mem_word_t  wdata;  // write data
   mem_pkg::mem_word_t  rdata;  // registered read data

   // bus decoder drives the request
   modport req (
      output valid, we, addr, wem, wdata
   );

   // array consumes the request, returns read data
   modport mem (
      input  valid, we, addr, wem, wdata,
      output rdata
   );

   // ack generator only looks
   modport mon (
      input valid, we, rdata
   );

endinterface

// File: logic/wb_ack_gen.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module wb_ack_gen (
   input  logic               clk,
   input  logic               rst_n,
   mem_req_if.mon             req,
   output logic               ack,
   output mem_pkg::mem_word_t dat_r
);

   logic rd_q;  // acked transaction was a read

   // ack lands on the same edge as the array access
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack  <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         ack  <= req.valid;
         rd_q <= req.valid && !req.we;
      end
   end

   // read data only on a read ack, zero on write acks and idle cycles
   assign dat_r = (ack && rd_q) ? req.rdata : '0;

   // decoder pending flag keeps this a pulse
   a_ack_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      ack |=> !ack
   );

endmodule

// File: logic/wb_req_decode.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module wb_req_decode (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  mem_pkg::mem_addr_t adr,
   input  mem_pkg::mem_sel_t  sel,
   input  mem_pkg::mem_word_t dat_w,
   input  logic               busy,    // clear walk still running
   mem_req_if.req             req
);

   logic               pending;  // request already issued for this stb
   logic               issue;
   mem_pkg::mem_word_t wem_exp;  // byte selects widened to bits

   // raise the request on the first cycle the strobe is seen with the array free
   assign issue = cyc && stb && !busy && !pending;

   // each select bit covers one byte lane
   always_comb begin
      for (int i = 0; i < `MEM_SW; i++) begin
         wem_exp[i*(`MEM_DW/`MEM_SW) +: (`MEM_DW/`MEM_SW)] = {(`MEM_DW/`MEM_SW){sel[i]}};
      end
   end

   assign req.valid = issue;
   assign req.we    = we;
   assign req.addr  = adr;
   assign req.wem   = we ? wem_exp : '0;  // no mask bits on a read
   assign req.wdata = dat_w;

   // held strobe must not issue again
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (!(cyc && stb)) begin
         pending <= 1'b0;                  // master dropped stb so ready for next
      end else if (issue) begin
         pending <= 1'b1;
      end
   end

   // one request per transaction even with stb held
   a_single_req : assert property (
      @(posedge clk) disable iff (!rst_n)
      req.valid |=> !req.valid
   );

endmodule

// File: logic/wb_sram_top.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module wb_sram_top (
   input  logic               clk,
   input  logic               rst_n,
   // wishbone classic slave
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  mem_pkg::mem_addr_t adr,
   input  mem_pkg::mem_sel_t  sel,
   input  mem_pkg::mem_word_t dat_w,
   output logic               ack,
   output mem_pkg::mem_word_t dat_r,
   // status
   output logic               busy       // post reset clear in progress
);

   logic               clr_en;
   mem_pkg::mem_addr_t clr_addr;

   mem_req_if req_bus ();  // decoder -> array -> ack

   wb_req_decode u_req_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .sel   (sel),
      .dat_w (dat_w),
      .busy  (busy),
      .req   (req_bus.req)
   );

   mem_clear u_mem_clear (
      .clk      (clk),
      .rst_n    (rst_n),
      .busy     (busy),
      .clr_en   (clr_en),
      .clr_addr (clr_addr)
   );

   mem_sp u_mem_sp (
      .clk      (clk),
      .req      (req_bus.mem),
      .clr_en   (clr_en),
      .clr_addr (clr_addr)
   );

   wb_ack_gen u_ack_gen (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req_bus.mon),
      .ack   (ack),
      .dat_r (dat_r)
   );

endmodule

// File: memory/mem_clear.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_clear (
   input  logic               clk,
   input  logic               rst_n,
   output logic               busy,      // high for the whole walk
   output logic               clr_en,
   output mem_pkg::mem_addr_t clr_addr
);

   logic clr_active;  // walk in progress
   logic last_word;

   assign last_word = (clr_addr == mem_pkg::mem_addr_t'(`MEM_DEPTH - 1));

   // one word per cycle from address zero then stop for good
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clr_active <= 1'b1;
         clr_addr   <= '0;
      end else if (clr_active) begin
         if (last_word) begin
            clr_active <= 1'b0;           // walk done and addr parks here
         end else begin
            clr_addr <= clr_addr + 1'b1;
         end
      end
   end

   assign clr_en = clr_active;
   assign busy   = clr_active;  // bus side waits on the same flag

   // counter only moves as part of a clear write
   a_addr_step : assert property (
      @(posedge clk) disable iff (!rst_n)
      (clr_addr != $past(clr_addr)) |-> $past(clr_en)
   );

endmodule

// File: memory/mem_sp.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_sp (
   input  logic               clk,
   mem_req_if.mem             req,
   input  logic               clr_en,    // maintenance write, zero word
   input  mem_pkg::mem_addr_t clr_addr
);

   mem_pkg::mem_word_t ram [`MEM_DEPTH];  // behavioural array, fpga inference
   mem_pkg::mem_addr_t wr_addr;
   mem_pkg::mem_word_t wr_mask;
   mem_pkg::mem_word_t wr_data;
   logic               wr_en;

   // port mux, maintenance side wins
   always_comb begin
      if (clr_en) begin
         wr_en   = 1'b1;
         wr_addr = clr_addr;
         wr_mask = '1;                    // full word
         wr_data = '0;
      end else begin
         wr_en   = req.valid && req.we;
         wr_addr = req.addr;
         wr_mask = req.wem;
         wr_data = req.wdata;
      end
   end

   // bit masked write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < `MEM_DW; i++) begin
            if (wr_mask[i]) begin
               ram[wr_addr][i] <= wr_data[i];
            end
         end
      end
   end

   // read port, one cycle latency
   // holds last value between reads
   always_ff @(posedge clk) begin
      if (req.valid && !req.we && !clr_en) begin
         req.rdata <= ram[req.addr];
      end
   end

   // decoder holds off while the clear walk runs
   a_no_port_clash : assert property (
      @(posedge clk)
      !(req.valid && clr_en)
   );

endmodule

// File: tests/tb_wb_sram.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module tb_wb_sram;

   localparam int ACK_TIMEOUT = 2 * `MEM_DEPTH + 16;  // room for a request parked behind the walk
   localparam int SWEEP_N     = 12;

   logic               clk;
   logic               rst_n;
   logic               cyc;
   logic               stb;
   logic               we;
   mem_pkg::mem_addr_t adr;
   mem_pkg::mem_sel_t  sel;
   mem_pkg::mem_word_t dat_w;
   logic               ack;
   mem_pkg::mem_word_t dat_r;
   logic               busy;

   mem_pkg::mem_word_t model [`MEM_DEPTH];  // expected array contents
   int                 errors;
   int                 aborts;     // waits that ran out or missing vectors
   int                 n_trans;    // transactions finished
   int                 ack_total;  // acks seen on the bus

   wb_sram_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // every ack pulse counted once
   always @(negedge clk) begin
      if (rst_n && ack) ack_total++;
   end

   // wishbone byte lane rule with 8 bits per select
   function automatic mem_pkg::mem_word_t merge_bytes(input mem_pkg::mem_word_t old_w,
                                                      input mem_pkg::mem_word_t new_w,
                                                      input mem_pkg::mem_sel_t  s);
      mem_pkg::mem_word_t w;
      w = old_w;
      for (int i = 0; i < `MEM_SW; i++) begin
         if (s[i]) w[i*8 +: 8] = new_w[i*8 +: 8];
      end
      return w;
   endfunction

   task automatic check_word(input string name, input mem_pkg::mem_word_t exp,
                             input mem_pkg::mem_word_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic record_abort(input string why);
      $display("%s", why);
      aborts++;
   endtask

   task automatic wait_busy_low();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (busy && n < ACK_TIMEOUT);
      if (busy) record_abort("timeout: busy never dropped after reset");
   endtask

   // one classic cycle with stb held until ack plus a random hold
   task automatic bus_xfer(input logic wr, input mem_pkg::mem_addr_t a,
                           input mem_pkg::mem_sel_t s, input mem_pkg::mem_word_t d,
                           input logic lat_chk, output mem_pkg::mem_word_t rd);
      int   n;
      int   hold;
      logic got;
      n    = 0;
      got  = 1'b0;
      rd   = '0;
      hold = $urandom % 5;
      @(posedge clk);
      check_flag("ack_count", 1'b1, ack_total == n_trans);  // no stray ack from last one
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= wr;
      adr   <= a;
      sel   <= s;
      dat_w <= d;
      while (!got && n < ACK_TIMEOUT) begin
         @(negedge clk);
         n++;
         got = ack;
      end
      if (!got) begin
         record_abort($sformatf("timeout: no ack for %s at address %h",
                                wr ? "write" : "read", a));
      end else begin
         if (lat_chk) check_flag("ack_one_cycle", 1'b1, n == 2);  // ack one edge after stb
         rd = dat_r;
         if (wr) check_word("dat_r_on_write", '0, dat_r);  // write ack carries no data
         repeat (hold) @(posedge clk);   // stb still high here
      end
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
      if (got) n_trans++;
      repeat ($urandom % 3) @(posedge clk);  // idle gap
   endtask

   initial begin
      int                 fd;
      int                 rc;
      int                 nf;
      int                 op;
      string              line;
      logic               first;
      mem_pkg::mem_addr_t a;
      mem_pkg::mem_sel_t  s;
      mem_pkg::mem_word_t d;
      mem_pkg::mem_word_t e;
      mem_pkg::mem_word_t rd;
      mem_pkg::mem_addr_t sw_addr [SWEEP_N];

      void'($urandom(32'h3b4a2730));
      errors    = 0;
      aborts    = 0;
      n_trans   = 0;
      ack_total = 0;
      rst_n     = 1'b0;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      sel       = '0;
      dat_w     = '0;
      for (int i = 0; i < `MEM_DEPTH; i++) model[i] = '0;  // clear walk result
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_flag("busy", 1'b1, busy);

      fd = $fopen("tests/wb_sram_tests.txt", "r");
      if (fd == 0) begin
         record_abort("could not open the vector file tests/wb_sram_tests.txt");
      end else begin
         first = 1'b1;  // first op goes out while the walk runs
         while (!$feof(fd) && aborts == 0) begin
            rc = $fgets(line, fd);
            nf = $sscanf(line, "%h %h %h %h %h", op, a, s, d, e);
            if (rc > 0 && line[0] != "#" && nf == 5) begin
               if (!first) wait_busy_low();
               if (aborts == 0) bus_xfer(op != 0, a, s, d, !first, rd);
               if (aborts == 0) begin
                  if (op != 0) model[a] = merge_bytes(model[a], d, s);
                  else check_word("dat_r", e, rd);
                  if (first) check_flag("busy", 1'b0, busy);  // walk over before parked op
               end
               first = 1'b0;
            end
         end
         $fclose(fd);
      end

      // random sweep with all writes first and then the read back
      for (int i = 0; i < SWEEP_N && aborts == 0; i++) begin
         a          = mem_pkg::mem_addr_t'($urandom);
         s          = mem_pkg::mem_sel_t'($urandom);
         d          = $urandom;
         sw_addr[i] = a;
         bus_xfer(1'b1, a, s, d, 1'b1, rd);
         if (aborts == 0) model[a] = merge_bytes(model[a], d, s);
      end
      for (int i = 0; i < SWEEP_N && aborts == 0; i++) begin
         bus_xfer(1'b0, sw_addr[i], '0, '0, 1'b1, rd);
         if (aborts == 0) check_word("dat_r", model[sw_addr[i]], rd);
      end

      repeat (2) @(posedge clk);
      if (aborts == 0) check_flag("ack_count", 1'b1, ack_total == n_trans);
      $display("closing: %0d errors, %0d aborts, %0d transactions", errors, aborts, n_trans);
      if (errors == 0 && aborts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: tests/wb_sram_tests.txt
# columns: op addr sel data expect, all hex; op 1 = write, 0 = read
# expect is only compared on reads; the first line is issued while the clear walk runs
1 10 f 11223344 00000000
0 10 0 00000000 11223344
0 00 0 00000000 00000000
0 ff 0 00000000 00000000
0 7f 0 00000000 00000000
0 11 0 00000000 00000000
1 20 f deadbeef 00000000
0 20 0 00000000 deadbeef
1 20 1 000000a5 00000000
0 20 0 00000000 deadbea5
1 20 6 12345678 00000000
0 20 0 00000000 de3456a5
1 20 8 99000000 00000000
0 20 0 00000000 993456a5
1 30 3 cafef00d 00000000
0 30 0 00000000 0000f00d
1 ff f 5a5a5a5a 00000000
0 ff 0 00000000 5a5a5a5a
1 ff 0 ffffffff 00000000
0 ff 0 00000000 5a5a5a5a
0 10 0 00000000 11223344
0 20 0 00000000 993456a5

// File: verilog.f
+incdir+common
common/mem_pkg.sv
common/mem_req_if.sv
logic/wb_req_decode.sv
memory/mem_sp.sv
memory/mem_clear.sv
logic/wb_ack_gen.sv
logic/wb_sram_top.sv
tests/tb_wb_sram.sv
